/* snoop_filter.f */
+incdir+dv
rtl/snoop_filter_pkg.sv
rtl/sf_tag_array.sv
rtl/sf_target_select.sv
rtl/sf_snoop_ctrl.sv
rtl/snoop_filter.sv
dv/tb_snoop_filter.sv

/* run.sh */
#!/bin/sh
# Build and run the snoop filter testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f snoop_filter.f \
    --top-module tb_snoop_filter \
    -o sim_snoop_filter

# A failing run still leaves its log to be searched
./obj_dir/sim_snoop_filter 2>&1 | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* dv/sf_ref_model.svh */
// =========================================================================
// Snoop filter reference model
// Shadow tag array, tracking mirror, expected snoop result,
// typed compare tasks
// =========================================================================

`ifndef SF_REF_MODEL_SVH
`define SF_REF_MODEL_SVH

filter_entry_t shadow [num_sets][num_ways];
sf_stats_t     exp_stats;

function automatic void init_model();
    for (int s = 0; s < num_sets; s++) begin
        for (int w = 0; w < num_ways; w++) begin
            shadow[s][w] = '0;
        end
    end
    exp_stats = '0;
endfunction

// Way holding the line, or -1 when untracked
function automatic int shadow_way(input addr_t addr);
    set_idx_t s;
    tag_t     t;
    int       way;
    s   = addr[line_offset_bits +: set_bits];
    t   = addr[addr_width-1 -: tag_bits];
    way = -1;
    for (int w = 0; w < num_ways; w++) begin
        if (shadow[s][w].valid && (shadow[s][w].tag == t)) begin
            way = w;
        end
    end
    return way;
endfunction

function automatic void mirror_track(input track_req_t t);
    set_idx_t s;
    int       way;
    lru_age_t oldest;
    s   = t.addr[line_offset_bits +: set_bits];
    way = shadow_way(t.addr);
    case (t.op)
        track_add_sharer: begin
            if (way < 0) begin
                // Lowest free way
                for (int w = num_ways - 1; w >= 0; w--) begin
                    if (!shadow[s][w].valid) begin
                        way = w;
                    end
                end
                // Else the oldest, highest way on a tie
                if (way < 0) begin
                    oldest = '0;
                    for (int w = 0; w < num_ways; w++) begin
                        if (shadow[s][w].age >= oldest) begin
                            oldest = shadow[s][w].age;
                            way    = w;
                        end
                    end
                end
                shadow[s][way].valid   = 1'b1;
                shadow[s][way].tag     = t.addr[addr_width-1 -: tag_bits];
                shadow[s][way].sharers = '0;
            end
            shadow[s][way].sharers[t.node] = 1'b1;
            for (int w = 0; w < num_ways; w++) begin
                if (w == way) begin
                    shadow[s][w].age = '0;
                end else if (shadow[s][w].age != 2'd3) begin
                    shadow[s][w].age = shadow[s][w].age + 2'd1;
                end
            end
        end
        track_remove_sharer: begin
            if (way >= 0) begin
                shadow[s][way].sharers[t.node] = 1'b0;
                if (shadow[s][way].sharers == '0) begin
                    shadow[s][way].valid = 1'b0;
                end
            end
        end
        track_set_exclusive: begin
            if (way >= 0) begin
                shadow[s][way].sharers          = '0;
                shadow[s][way].sharers[t.node] = 1'b1;
            end
        end
        default: begin
            if (way >= 0) begin
                shadow[s][way].valid   = 1'b0;
                shadow[s][way].sharers = '0;
            end
        end
    endcase
endfunction

// Expected output for one snoop, counters advanced in st
function automatic snoop_out_t predict_snoop(input snoop_req_t r, input sf_cfg_t c,
                                             inout sf_stats_t st);
    snoop_out_t o;
    node_mask_t sharers;
    set_idx_t   s;
    int         way;
    logic       bcast;
    s       = r.addr[line_offset_bits +: set_bits];
    way     = shadow_way(r.addr);
    sharers = '0;
    if (way >= 0) begin
        sharers = shadow[s][way].sharers;
    end
    bcast = c.bcast_mode || !c.filter_en || (way < 0)
            || ($countones(sharers) >= int'(c.threshold));
    o.addr    = r.addr;
    o.opcode  = r.opcode;
    o.src     = r.src;
    o.targets = bcast ? '1 : sharers;
    o.targets[r.src] = 1'b0;
    st.total = st.total + stat_count_t'(1);
    if (bcast) begin
        st.bcast = st.bcast + stat_count_t'(1);
    end else begin
        st.filtered = st.filtered + stat_count_t'(1);
    end
    return o;
endfunction

task automatic check_out(input string name, input snoop_out_t exp, input snoop_out_t act);
    if (act !== exp) begin
        abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_stats(input string name, input sf_stats_t exp, input sf_stats_t act);
    if (act !== exp) begin
        abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    end
endtask

`endif

/* dv/tb_snoop_filter.sv */
// =========================================================================
// Testbench for the snoop filter
// Directed sequences for miss, hit, overrides, tracking and replacement,
// then random traffic with output stalls
// =========================================================================

module tb_snoop_filter
    import snoop_filter_pkg::*;
();

    // Worst case per random iteration plus the directed sequences
    localparam int rand_iters      = 160;
    localparam int iter_cycles     = 16;
    localparam int directed_cycles = 440;
    localparam int max_cycles      = rand_iters * iter_cycles + directed_cycles;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_ready;
    snoop_req_t req;
    logic       out_valid;
    logic       out_ready;
    snoop_out_t out;
    logic       track_valid;
    track_req_t track;
    sf_cfg_t    cfg;
    sf_stats_t  stats;

    logic [31:0] lfsr_state = 32'h233d;
    int          cycle_count = 0;

    // Expected responses in issue order
    snoop_out_t exp_out_q [$];
    sf_stats_t  exp_stats_q [$];
    string      name_q [$];

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Run stopped on error");
    endtask

    `include "sf_ref_model.svh"

    snoop_filter dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out         (out),
        .track_valid (track_valid),
        .track       (track),
        .cfg         (cfg),
        .stats       (stats)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // =========================================================================
    // Stimulus helpers
    // =========================================================================

    // Galois LFSR stepped once per bit
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // Random byte offset within the line
    function automatic addr_t line_addr(input tag_t t, input set_idx_t s);
        return {t, s, 6'(take_bits(6))};
    endfunction

    task automatic set_cfg(input logic en, input logic bmode, input threshold_t thr);
        @(negedge clk);
        cfg.filter_en  = en;
        cfg.bcast_mode = bmode;
        cfg.threshold  = thr;
    endtask

    task automatic apply_track(input addr_t addr, input node_id_t node, input track_op_e op);
        track_req_t t;
        t.addr = addr;
        t.node = node;
        t.op   = op;
        @(negedge clk);
        track_valid = 1'b1;
        track       = t;
        mirror_track(t);
        @(negedge clk);
        track_valid = 1'b0;
    endtask

    // One snoop from request to handshake with an output stall of stall cycles
    task automatic run_snoop(input string name, input addr_t addr, input node_id_t src,
                             input int stall);
        snoop_req_t r;
        snoop_out_t exp_resp;
        r.addr   = addr;
        r.opcode = snp_opcode_e'(take_bits(2));
        r.src    = src;
        exp_resp = predict_snoop(r, cfg, exp_stats);
        name_q.push_back(name);
        exp_out_q.push_back(exp_resp);
        exp_stats_q.push_back(exp_stats);
        @(negedge clk);
        req_valid = 1'b1;
        req       = r;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
        while (!out_valid) begin
            @(negedge clk);
        end
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            check_out({name, " output held"}, exp_resp, out);
            check_bit({name, " out_valid held"}, 1'b1, out_valid);
            check_bit({name, " req_ready in stall"}, 1'b0, req_ready);
        end
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
        check_bit({name, " out_valid after handshake"}, 1'b0, out_valid);
    endtask

    // =========================================================================
    // Compare process and timeout
    // =========================================================================

    always @(posedge clk) begin : compare_resp
        string name;
        if (rst_n && out_valid && out_ready) begin
            if (exp_out_q.size() == 0) begin
                abort_run("A snoop response came out with no request pending");
            end else begin
                name = name_q.pop_front();
                check_out(name, exp_out_q.pop_front(), out);
                check_stats({name, " stats"}, exp_stats_q.pop_front(), stats);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            abort_run($sformatf("Timeout after %0d cycles, the run did not finish",
                                max_cycles));
        end
    end

    // =========================================================================
    // Test sequence
    // =========================================================================

    initial begin
        addr_t line_a;
        addr_t line_b;
        addr_t a;
        tag_t  repl_tags [5];
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        out_ready   = 1'b0;
        track_valid = 1'b0;
        track       = '0;
        cfg         = '0;
        init_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        set_cfg(1'b1, 1'b0, 4'd8);

        // Miss and filtered hit on one line
        line_a = line_addr(tag_t'(take_bits(22)), 4'd3);
        run_snoop("miss broadcast", line_a, 4'd5, 0);
        apply_track(line_a, 4'd2, track_add_sharer);
        apply_track(line_a, 4'd5, track_add_sharer);
        apply_track(line_a, 4'd9, track_add_sharer);
        run_snoop("filtered hit", line_a, 4'd5, 0);

        // Broadcast overrides
        set_cfg(1'b1, 1'b0, 4'd3);
        run_snoop("threshold broadcast", line_a, 4'd2, 0);
        set_cfg(1'b1, 1'b1, 4'd8);
        run_snoop("broadcast mode", line_a, 4'd2, 0);
        set_cfg(1'b0, 1'b0, 4'd8);
        run_snoop("filter disabled", line_a, 4'd2, 0);
        set_cfg(1'b1, 1'b0, 4'd8);

        // Tracking updates
        apply_track(line_a, 4'd9, track_set_exclusive);
        run_snoop("set exclusive", line_a, 4'd0, 0);
        apply_track(line_a, 4'd9, track_remove_sharer);
        run_snoop("last sharer removed", line_a, 4'd0, 0);
        line_b = line_addr(tag_t'(take_bits(22)), 4'd3);
        apply_track(line_b, 4'd4, track_add_sharer);
        apply_track(line_b, 4'd11, track_add_sharer);
        apply_track(line_b, 4'd4, track_invalidate);
        run_snoop("invalidated line", line_b, 4'd1, 0);

        // Replacement in set 7 where the second line ages out
        for (int i = 0; i < 5; i++) begin
            repl_tags[i] = {19'(take_bits(19)), 3'(i)};
        end
        for (int i = 0; i < 4; i++) begin
            apply_track(line_addr(repl_tags[i], 4'd7), node_id_t'(i), track_add_sharer);
        end
        apply_track(line_addr(repl_tags[0], 4'd7), 4'd8, track_add_sharer);
        apply_track(line_addr(repl_tags[4], 4'd7), 4'd12, track_add_sharer);
        for (int i = 0; i < 5; i++) begin
            run_snoop($sformatf("replacement line %0d", i), line_addr(repl_tags[i], 4'd7),
                      4'd15, 0);
        end

        // Random traffic with output stalls on a small pool of lines
        for (int i = 0; i < rand_iters; i++) begin
            if (i % 32 == 0) begin
                set_cfg(take_bits(3) != 0, take_bits(4) == 0,
                        threshold_t'(take_bits(2) + 2));
            end
            a = line_addr(tag_t'(22'h2a000 + take_bits(3)), set_idx_t'(take_bits(2)));
            apply_track(a, node_id_t'(take_bits(4)), track_op_e'(take_bits(2)));
            a = line_addr(tag_t'(22'h2a000 + take_bits(3)), set_idx_t'(take_bits(2)));
            run_snoop("random traffic", a, node_id_t'(take_bits(4)), take_bits(2));
        end

        repeat (2) @(negedge clk);
        if (exp_out_q.size() != 0) begin
            abort_run("Some snoops never produced a response");
        end else if (stats.total != stats.filtered + stats.bcast) begin
            abort_run("Total count differs from filtered plus broadcast");
        end else begin
            check_stats("final counts", exp_stats, stats);
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* rtl/snoop_filter.sv */
// =========================================================================
// Snoop filter top level
// Tag array, target select and snoop controller
// =========================================================================

module snoop_filter
    import snoop_filter_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Snoop request in
    input  logic       req_valid,
    output logic       req_ready,
    input  snoop_req_t req,

    // Filtered snoop out
    output logic       out_valid,
    input  logic       out_ready,
    output snoop_out_t out,

    // Directory tracking, no back-pressure
    input  logic       track_valid,
    input  track_req_t track,

    input  sf_cfg_t    cfg,
    output sf_stats_t  stats
);

    snoop_req_t     held_req;
    lookup_result_t lookup;
    node_mask_t     targets;
    logic           broadcast;

    sf_tag_array u_tag_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .track_valid (track_valid),
        .track       (track),
        .lookup_addr (held_req.addr),
        .lookup      (lookup)
    );

    sf_target_select u_target_select (
        .lookup    (lookup),
        .cfg       (cfg),
        .src       (held_req.src),
        .targets   (targets),
        .broadcast (broadcast)
    );

    sf_snoop_ctrl u_snoop_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .held_req  (held_req),
        .targets   (targets),
        .broadcast (broadcast),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out),
        .stats     (stats)
    );

endmodule

/* rtl/sf_snoop_ctrl.sv */
// =========================================================================
// Snoop request controller
// FSM with request capture, registered output and statistics counters
// =========================================================================

module sf_snoop_ctrl
    import snoop_filter_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Incoming snoop
    input  logic       req_valid,
    output logic       req_ready,
    input  snoop_req_t req,

    // Captured request, looked up by the tag array
    output snoop_req_t held_req,

    // Decision from the target select
    input  node_mask_t targets,
    input  logic       broadcast,

    // Filtered snoop out
    output logic       out_valid,
    input  logic       out_ready,
    output snoop_out_t out,

    output sf_stats_t  stats
);

    sf_state_e state;
    sf_state_e state_next;
    logic      accept;

    // =========================================================================
    // Handshakes
    // =========================================================================

    // One snoop in flight, so ready only while idle
    assign req_ready = (state == sf_idle);
    assign accept    = req_valid && req_ready;
    assign out_valid = (state == sf_respond);

    // =========================================================================
    // FSM
    // =========================================================================

    always_comb begin
        state_next = state;
        case (state)
            sf_idle: begin
                if (accept) begin
                    state_next = sf_lookup;
                end
            end
            sf_lookup: begin
                state_next = sf_respond;
            end
            sf_respond: begin
                if (out_ready) begin
                    state_next = sf_idle;
                end
            end
            default: begin
                state_next = sf_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= sf_idle;
        end else begin
            state <= state_next;
        end
    end

    // =========================================================================
    // Request capture and output register
    // =========================================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            held_req <= req;
        end
    end

    // Loaded once per snoop, then held through any stall
    always_ff @(posedge clk) begin
        if (state == sf_lookup) begin
            out.addr    <= held_req.addr;
            out.opcode  <= held_req.opcode;
            out.targets <= targets;
            out.src     <= held_req.src;
        end
    end

    // =========================================================================
    // Statistics
    // =========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stats <= '0;
        end else if (state == sf_lookup) begin
            stats.total <= stats.total + stat_count_t'(1);
            if (broadcast) begin
                stats.bcast <= stats.bcast + stat_count_t'(1);
            end else begin
                stats.filtered <= stats.filtered + stat_count_t'(1);
            end
        end
    end

endmodule

/* rtl/sf_target_select.sv */
// =========================================================================
// Broadcast decision and snoop target mask
// =========================================================================

module sf_target_select
    import snoop_filter_pkg::*;
(
    input  lookup_result_t lookup,
    input  sf_cfg_t        cfg,
    input  node_id_t       src,
    output node_mask_t     targets,
    output logic           broadcast
);

    sharer_count_t sharer_count;
    node_mask_t    src_bit;
    node_mask_t    base_mask;

    // Population count of the hit mask
    always_comb begin
        sharer_count = '0;
        for (int i = 0; i < num_nodes; i++) begin
            sharer_count = sharer_count + sharer_count_t'(lookup.sharers[i]);
        end
    end

    // Any one of these forces a broadcast
    assign broadcast = cfg.bcast_mode
                    || !cfg.filter_en
                    || !lookup.hit
                    || (sharer_count >= sharer_count_t'(cfg.threshold));

    assign base_mask = broadcast ? '1 : lookup.sharers;

    // The requester is never snooped
    assign src_bit = node_mask_t'(1) << src;
    assign targets = base_mask & ~src_bit;

endmodule

/* rtl/sf_tag_array.sv */
// =========================================================================
// Four-way set-associative sharer tag array
// Separate compare paths for snoop lookup and directory tracking,
// victim choice by age, tracking updates applied in one cycle
// =========================================================================

module sf_tag_array
    import snoop_filter_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           track_valid,
    input  track_req_t     track,
    input  addr_t          lookup_addr,
    output lookup_result_t lookup
);

    filter_entry_t entries [num_sets][num_ways];

    // Tracking path
    set_idx_t            trk_set;
    tag_t                trk_tag;
    node_mask_t          node_bit;
    logic [num_ways-1:0] trk_hit;
    way_idx_t            hit_way;
    way_idx_t            victim_way;
    filter_entry_t       set_next [num_ways];

    // Snoop lookup path
    set_idx_t lk_set;
    tag_t     lk_tag;

    function automatic set_idx_t addr_set(addr_t addr);
        return addr[line_offset_bits +: set_bits];
    endfunction

    function automatic tag_t addr_tag(addr_t addr);
        return addr[addr_width-1 -: tag_bits];
    endfunction

    // =========================================================================
    // Tracking compare and victim choice
    // =========================================================================

    assign trk_set  = addr_set(track.addr);
    assign trk_tag  = addr_tag(track.addr);
    assign node_bit = node_mask_t'(1) << track.node;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            trk_hit[w] = entries[trk_set][w].valid && (entries[trk_set][w].tag == trk_tag);
        end
    end

    // At most one way matches
    always_comb begin
        hit_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (trk_hit[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    // Oldest way, highest index on a tie; a free way takes precedence
    always_comb begin
        lru_age_t oldest;
        oldest     = '0;
        victim_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (entries[trk_set][w].age >= oldest) begin
                oldest     = entries[trk_set][w].age;
                victim_way = way_idx_t'(w);
            end
        end
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!entries[trk_set][w].valid) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

    // =========================================================================
    // Next contents of the tracked set
    // =========================================================================

    always_comb begin
        way_idx_t acc_way;
        acc_way = (|trk_hit) ? hit_way : victim_way;
        for (int w = 0; w < num_ways; w++) begin
            set_next[w] = entries[trk_set][w];
        end
        case (track.op)
            track_add_sharer: begin
                if (|trk_hit) begin
                    set_next[acc_way].sharers = set_next[acc_way].sharers | node_bit;
                end else begin
                    set_next[acc_way].valid   = 1'b1;
                    set_next[acc_way].tag     = trk_tag;
                    set_next[acc_way].sharers = node_bit;
                end
                // Accessed way becomes youngest, the rest age and saturate
                for (int w = 0; w < num_ways; w++) begin
                    if (way_idx_t'(w) == acc_way) begin
                        set_next[w].age = '0;
                    end else if (set_next[w].age != '1) begin
                        set_next[w].age = set_next[w].age + lru_age_t'(1);
                    end
                end
            end
            track_remove_sharer: begin
                if (|trk_hit) begin
                    set_next[hit_way].sharers = set_next[hit_way].sharers & ~node_bit;
                    // Last sharer gone
                    if (entries[trk_set][hit_way].sharers == node_bit) begin
                        set_next[hit_way].valid = 1'b0;
                    end
                end
            end
            track_set_exclusive: begin
                if (|trk_hit) begin
                    set_next[hit_way].sharers = node_bit;
                end
            end
            track_invalidate: begin
                if (|trk_hit) begin
                    set_next[hit_way].valid   = 1'b0;
                    set_next[hit_way].sharers = '0;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    entries[s][w] <= '0;
                end
            end
        end else if (track_valid) begin
            for (int w = 0; w < num_ways; w++) begin
                entries[trk_set][w] <= set_next[w];
            end
        end
    end

    // =========================================================================
    // Snoop lookup
    // =========================================================================

    assign lk_set = addr_set(lookup_addr);
    assign lk_tag = addr_tag(lookup_addr);

    always_comb begin
        lookup = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (entries[lk_set][w].valid && (entries[lk_set][w].tag == lk_tag)) begin
                lookup.hit     = 1'b1;
                lookup.sharers = lookup.sharers | entries[lk_set][w].sharers;
            end
        end
    end

endmodule

/* rtl/snoop_filter_pkg.sv */
// =========================================================================
// Shared definitions for the snoop filter
// Geometry constants, vector types, opcode and state enums, bus structs
// =========================================================================

package snoop_filter_pkg;

    // =========================================================================
    // Geometry
    // =========================================================================

    localparam int num_sets         = 16;
    localparam int num_ways         = 4;
    localparam int num_nodes        = 16;
    localparam int line_offset_bits = 6;
    localparam int addr_width       = 32;
    localparam int set_bits         = $clog2(num_sets);
    localparam int tag_bits         = addr_width - set_bits - line_offset_bits;

    // =========================================================================
    // Vector types
    // =========================================================================

    typedef logic [addr_width-1:0]          addr_t;
    typedef logic [$clog2(num_nodes)-1:0]   node_id_t;
    typedef logic [num_nodes-1:0]           node_mask_t;
    typedef logic [tag_bits-1:0]            tag_t;
    typedef logic [set_bits-1:0]            set_idx_t;
    typedef logic [$clog2(num_ways)-1:0]    way_idx_t;
    typedef logic [1:0]                     lru_age_t;
    typedef logic [$clog2(num_nodes+1)-1:0] sharer_count_t;
    typedef logic [3:0]                     threshold_t;
    typedef logic [31:0]                    stat_count_t;

    // =========================================================================
    // Enums
    // =========================================================================

    // Snoop kind, carried through to the output untouched
    typedef enum logic [1:0] {
        snp_shared  = 2'd0,
        snp_unique  = 2'd1,
        snp_clean   = 2'd2,
        snp_invalid = 2'd3
    } snp_opcode_e;

    // Directory tracking operations
    typedef enum logic [1:0] {
        track_add_sharer    = 2'd0,
        track_remove_sharer = 2'd1,
        track_set_exclusive = 2'd2,
        track_invalidate    = 2'd3
    } track_op_e;

    typedef enum logic [1:0] {
        sf_idle    = 2'd0,
        sf_lookup  = 2'd1,
        sf_respond = 2'd2
    } sf_state_e;

    // =========================================================================
    // Structs
    // =========================================================================

    typedef struct packed {
        addr_t       addr;
        snp_opcode_e opcode;
        node_id_t    src;
    } snoop_req_t;

    typedef struct packed {
        addr_t       addr;
        snp_opcode_e opcode;
        node_mask_t  targets;
        node_id_t    src;
    } snoop_out_t;

    typedef struct packed {
        addr_t     addr;
        node_id_t  node;
        track_op_e op;
    } track_req_t;

    // One way of one set in the tag array
    typedef struct packed {
        logic       valid;
        tag_t       tag;
        node_mask_t sharers;
        lru_age_t   age;
    } filter_entry_t;

    typedef struct packed {
        logic       hit;
        node_mask_t sharers;
    } lookup_result_t;

    typedef struct packed {
        logic       filter_en;
        logic       bcast_mode;
        threshold_t threshold;
    } sf_cfg_t;

    typedef struct packed {
        stat_count_t total;
        stat_count_t filtered;
        stat_count_t bcast;
    } sf_stats_t;

endpackage
